// ==== hdl/cpu_pkg.sv ====
// cpu_pkg: shared widths, opcodes and control encodings for the rv32i core
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 256;  // data memory depth in words
    localparam int DMEM_AW    = 8;    // word index bits

    typedef logic [XLEN-1:0] word_t;  // one data or address word
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_VECTOR = 32'h0000_0000;

    // major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // immediate format
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui, immediate straight through
    } alu_op_e;

    typedef enum logic {A_RS1, A_PC} alu_a_sel_e;

    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} alu_b_sel_e;

    // access width, extension chosen by a separate unsigned flag
    typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W} mem_size_e;

    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

endpackage

// ==== hdl/control_unit.sv ====
// control_unit: opcode decode into datapath selects plus branch resolution
`timescale 1ns/1ps

module control_unit (
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic                    funct7_b5,  // instr bit 30
    input  logic                    less,
    input  logic                    zero,
    output logic                    reg_wen,
    output cpu_pkg::imm_sel_e       imm_sel,
    output cpu_pkg::alu_op_e        alu_op,
    output cpu_pkg::alu_a_sel_e     alu_a_sel,
    output cpu_pkg::alu_b_sel_e     alu_b_sel,
    output logic                    mem_read,
    output logic                    mem_write,
    output cpu_pkg::mem_size_e      mem_size,
    output logic                    mem_unsigned,
    output cpu_pkg::wb_sel_e        wb_sel,
    output logic                    pc_a_imm,   // offset is imm, else 4
    output logic                    pc_b_rs1    // base is rs1, else pc
);

    always_comb begin
        // defaults act as a nop: no writes, pc + 4
        reg_wen      = 1'b0;
        imm_sel      = cpu_pkg::IMM_I;
        alu_op       = cpu_pkg::ALU_ADD;
        alu_a_sel    = cpu_pkg::A_RS1;
        alu_b_sel    = cpu_pkg::B_RS2;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_size     = cpu_pkg::SIZE_W;
        mem_unsigned = 1'b0;
        wb_sel       = cpu_pkg::WB_ALU;
        pc_a_imm     = 1'b0;
        pc_b_rs1     = 1'b0;

        case (opcode)
            cpu_pkg::OP_LUI: begin
                reg_wen   = 1'b1;
                imm_sel   = cpu_pkg::IMM_U;
                alu_op    = cpu_pkg::ALU_PASS_B;
                alu_b_sel = cpu_pkg::B_IMM;
            end
            cpu_pkg::OP_AUIPC: begin
                reg_wen   = 1'b1;
                imm_sel   = cpu_pkg::IMM_U;
                alu_a_sel = cpu_pkg::A_PC;
                alu_b_sel = cpu_pkg::B_IMM;
            end
            cpu_pkg::OP_JAL, cpu_pkg::OP_JALR: begin
                reg_wen   = 1'b1;      // link = pc + 4 through the alu
                alu_a_sel = cpu_pkg::A_PC;
                alu_b_sel = cpu_pkg::B_FOUR;
                pc_a_imm  = 1'b1;
                pc_b_rs1  = (opcode == cpu_pkg::OP_JALR);
                imm_sel   = (opcode == cpu_pkg::OP_JALR) ? cpu_pkg::IMM_I : cpu_pkg::IMM_J;
            end
            cpu_pkg::OP_BRANCH: begin
                imm_sel = cpu_pkg::IMM_B;
                case (funct3)
                    3'b000: begin alu_op = cpu_pkg::ALU_SUB;  pc_a_imm = zero;  end // beq
                    3'b001: begin alu_op = cpu_pkg::ALU_SUB;  pc_a_imm = ~zero; end // bne
                    3'b100: begin alu_op = cpu_pkg::ALU_SLT;  pc_a_imm = less;  end // blt
                    3'b101: begin alu_op = cpu_pkg::ALU_SLT;  pc_a_imm = ~less; end // bge
                    3'b110: begin alu_op = cpu_pkg::ALU_SLTU; pc_a_imm = less;  end // bltu
                    3'b111: begin alu_op = cpu_pkg::ALU_SLTU; pc_a_imm = ~less; end // bgeu
                    default: pc_a_imm = 1'b0;  // reserved, falls through
                endcase
            end
            cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE: begin
                alu_b_sel    = cpu_pkg::B_IMM;  // addr = rs1 + imm
                mem_unsigned = funct3[2];       // lbu / lhu
                case (funct3[1:0])
                    2'b00:   mem_size = cpu_pkg::SIZE_B;
                    2'b01:   mem_size = cpu_pkg::SIZE_H;
                    default: mem_size = cpu_pkg::SIZE_W;
                endcase
                if (opcode == cpu_pkg::OP_LOAD) begin
                    reg_wen  = 1'b1;
                    mem_read = 1'b1;
                    wb_sel   = cpu_pkg::WB_MEM;
                end else begin
                    imm_sel   = cpu_pkg::IMM_S;
                    mem_write = 1'b1;
                end
            end
            cpu_pkg::OP_IMM, cpu_pkg::OP_REG: begin
                reg_wen   = 1'b1;
                alu_b_sel = (opcode == cpu_pkg::OP_REG) ? cpu_pkg::B_RS2 : cpu_pkg::B_IMM;
                case (funct3)
                    // bit 30 means sub only for register ops, addi has imm bits there
                    3'b000: alu_op = (opcode == cpu_pkg::OP_REG && funct7_b5) ?
                                     cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b001: alu_op = cpu_pkg::ALU_SLL;
                    3'b010: alu_op = cpu_pkg::ALU_SLT;
                    3'b011: alu_op = cpu_pkg::ALU_SLTU;
                    3'b100: alu_op = cpu_pkg::ALU_XOR;
                    3'b101: alu_op = funct7_b5 ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
                    3'b110: alu_op = cpu_pkg::ALU_OR;
                    default: alu_op = cpu_pkg::ALU_AND;
                endcase
            end
            default: ;  // fence, system and unknown leave defaults
        endcase
    end

endmodule

// ==== hdl/imm_decode.sv ====
// imm_decode: gathers and sign-extends the immediate for each format
`timescale 1ns/1ps

module imm_decode (
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::imm_sel_e imm_sel,
    output cpu_pkg::word_t    imm
);

    always_comb begin
        case (imm_sel)
            cpu_pkg::IMM_S:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpu_pkg::IMM_B:   // bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            cpu_pkg::IMM_U:   // upper twenty, low bits zero
                imm = {instr[31:12], 12'b0};
            cpu_pkg::IMM_J:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:          // I format
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== hdl/register_file.sv ====
// register_file: 32 x 32 integer registers, two async reads, one sync write
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr_a,
    input  cpu_pkg::reg_addr_t raddr_b,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    input  logic               wen,
    output cpu_pkg::word_t     rdata_a,
    output cpu_pkg::word_t     rdata_b
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin  // x0 never stored
            regs[waddr] <= wdata;
        end
    end

    // x0 forced to zero on both ports
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

// ==== hdl/alu.sv ====
// alu: add/sub, shifts, compares and logic ops with less and zero flags
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output logic             less,
    output logic             zero
);

    logic           sub_en;
    cpu_pkg::word_t b_in;
    cpu_pkg::word_t sum;
    logic           carry;
    logic           lt;    // signed a < b
    logic           ltu;   // unsigned a < b
    logic [4:0]     shamt;

    // compares share the subtractor
    assign sub_en = (op == cpu_pkg::ALU_SUB) || (op == cpu_pkg::ALU_SLT) ||
                    (op == cpu_pkg::ALU_SLTU);
    assign b_in   = sub_en ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_in} + {32'd0, sub_en};

    assign ltu   = ~carry;  // no carry out on a - b means borrow
    assign lt    = (a[31] != b[31]) ? a[31] : sum[31];
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_SUB:    result = sum;
            cpu_pkg::ALU_SLL:    result = a << shamt;
            cpu_pkg::ALU_SRL:    result = a >> shamt;
            cpu_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            cpu_pkg::ALU_SLT:    result = {31'd0, lt};
            cpu_pkg::ALU_SLTU:   result = {31'd0, ltu};
            cpu_pkg::ALU_XOR:    result = a ^ b;
            cpu_pkg::ALU_OR:     result = a | b;
            cpu_pkg::ALU_AND:    result = a & b;
            cpu_pkg::ALU_PASS_B: result = b;
            default:             result = '0;
        endcase
    end

    assign less = (op == cpu_pkg::ALU_SLTU) ? ltu : lt;
    assign zero = (result == '0);

endmodule

// ==== hdl/pc_unit.sv ====
// pc_unit: program counter register and next-pc adder
`timescale 1ns/1ps

module pc_unit (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t rs1_data,
    input  cpu_pkg::word_t imm,
    input  logic           pc_a_imm,
    input  logic           pc_b_rs1,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t dnpc
);

    cpu_pkg::word_t offset;
    cpu_pkg::word_t base;
    cpu_pkg::word_t sum;

    assign offset = pc_a_imm ? imm : 32'd4;
    assign base   = pc_b_rs1 ? rs1_data : pc;
    assign sum    = base + offset;

    // jalr target has bit 0 cleared
    assign dnpc = pc_b_rs1 ? {sum[31:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= cpu_pkg::RESET_VECTOR;
        end else begin
            pc <= dnpc;  // every edge, no stall
        end
    end

endmodule

// ==== hdl/data_mem.sv ====
// data_mem: byte-addressed data memory with lane-masked stores, extending loads
`timescale 1ns/1ps

module data_mem (
    input  logic               clk,
    input  cpu_pkg::word_t     addr,
    input  cpu_pkg::word_t     wdata,
    input  logic               read,
    input  logic               write,
    input  cpu_pkg::mem_size_e size,
    input  logic               is_unsigned,
    output cpu_pkg::word_t     rdata
);

    cpu_pkg::word_t mem [cpu_pkg::DMEM_WORDS];

    logic [cpu_pkg::DMEM_AW-1:0] widx;  // wraps modulo depth
    logic [1:0]                  boff;  // byte offset in word
    logic [3:0]                  be;
    cpu_pkg::word_t              wdata_sh;
    cpu_pkg::word_t              rword;
    cpu_pkg::word_t              rword_sh;
    cpu_pkg::word_t              ext;

    assign widx = addr[cpu_pkg::DMEM_AW+1:2];
    assign boff = addr[1:0];

    // byte enables from size and offset
    always_comb begin
        case (size)
            cpu_pkg::SIZE_B: be = 4'b0001 << boff;
            cpu_pkg::SIZE_H: be = 4'b0011 << boff;
            default:         be = 4'b1111;
        endcase
    end

    assign wdata_sh = wdata << {boff, 3'b000};  // move into lane

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (write && be[i]) begin
                mem[widx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
            end
        end
    end

    // async read, selected lane shifted down to bit 0
    assign rword    = mem[widx];
    assign rword_sh = rword >> {boff, 3'b000};

    always_comb begin
        case (size)
            cpu_pkg::SIZE_B:
                ext = {{24{~is_unsigned & rword_sh[7]}}, rword_sh[7:0]};
            cpu_pkg::SIZE_H:
                ext = {{16{~is_unsigned & rword_sh[15]}}, rword_sh[15:0]};
            default:
                ext = rword_sh;
        endcase
    end

    assign rdata = read ? ext : '0;  // quiet bus when not loading

endmodule

// ==== hdl/cpu.sv ====
// cpu: single-cycle rv32i core, field slicing, operand and writeback muxes
`timescale 1ns/1ps

module cpu (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::word_t     cmd,       // instruction for current pc
    output cpu_pkg::word_t     pc,
    output cpu_pkg::word_t     dnpc,
    output logic               rf_wen,    // writeback trace
    output cpu_pkg::reg_addr_t rf_waddr,
    output cpu_pkg::word_t     rf_wdata
);

    cpu_pkg::reg_addr_t rs1, rs2, rd;
    cpu_pkg::word_t     rs1_data, rs2_data, imm;
    cpu_pkg::word_t     alu_a, alu_b, alu_result, mem_rdata;
    logic               less, zero;

    // decoded controls
    cpu_pkg::imm_sel_e   imm_sel;
    cpu_pkg::alu_op_e    alu_op;
    cpu_pkg::alu_a_sel_e alu_a_sel;
    cpu_pkg::alu_b_sel_e alu_b_sel;
    cpu_pkg::mem_size_e  mem_size;
    cpu_pkg::wb_sel_e    wb_sel;
    logic                mem_read, mem_write, mem_unsigned;
    logic                pc_a_imm, pc_b_rs1;

    assign rs1 = cmd[19:15];
    assign rs2 = cmd[24:20];
    assign rd  = cmd[11:7];

    control_unit u_ctrl (
        .opcode(cmd[6:0]), .funct3(cmd[14:12]), .funct7_b5(cmd[30]),
        .less(less), .zero(zero),
        .reg_wen(rf_wen), .imm_sel(imm_sel), .alu_op(alu_op),
        .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
        .mem_read(mem_read), .mem_write(mem_write), .mem_size(mem_size),
        .mem_unsigned(mem_unsigned), .wb_sel(wb_sel),
        .pc_a_imm(pc_a_imm), .pc_b_rs1(pc_b_rs1)
    );

    imm_decode u_imm (.instr(cmd), .imm_sel(imm_sel), .imm(imm));

    register_file u_rf (
        .clk(clk), .raddr_a(rs1), .raddr_b(rs2),
        .waddr(rf_waddr), .wdata(rf_wdata), .wen(rf_wen),
        .rdata_a(rs1_data), .rdata_b(rs2_data)
    );

    // alu operand muxes
    assign alu_a = (alu_a_sel == cpu_pkg::A_PC) ? pc : rs1_data;
    always_comb begin
        case (alu_b_sel)
            cpu_pkg::B_IMM:  alu_b = imm;
            cpu_pkg::B_FOUR: alu_b = 32'd4;  // link address
            default:         alu_b = rs2_data;
        endcase
    end

    alu u_alu (
        .op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .less(less), .zero(zero)
    );

    pc_unit u_pc (
        .clk(clk), .rst(rst), .rs1_data(rs1_data), .imm(imm),
        .pc_a_imm(pc_a_imm), .pc_b_rs1(pc_b_rs1), .pc(pc), .dnpc(dnpc)
    );

    data_mem u_dmem (
        .clk(clk), .addr(alu_result), .wdata(rs2_data),
        .read(mem_read), .write(mem_write), .size(mem_size),
        .is_unsigned(mem_unsigned), .rdata(mem_rdata)
    );

    // writeback select, trace shows the rf write port
    assign rf_waddr = rd;
    assign rf_wdata = (wb_sel == cpu_pkg::WB_MEM) ? mem_rdata : alu_result;

endmodule

// ==== testbench/cpu_tb.sv ====
// cpu_tb: directed tests for the single-cycle rv32i core, testbench acts as instruction source
`timescale 1ns/1ps

module cpu_tb;

    // opcodes for assembling test programs
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam cpu_pkg::word_t NOP    = 32'h0000_0013;  // addi x0, x0, 0

    logic               clk;
    logic               rst;
    cpu_pkg::word_t     cmd;
    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     dnpc;
    logic               rf_wen;
    cpu_pkg::reg_addr_t rf_waddr;
    cpu_pkg::word_t     rf_wdata;

    cpu_pkg::word_t m_regs [32];   // reference register state
    logic [7:0]     m_mem [1024];  // reference byte memory, same wrap as dut
    cpu_pkg::word_t exp_pc;
    int             errors;
    int             seed;

    cpu uut (
        .clk(clk), .rst(rst), .cmd(cmd), .pc(pc), .dnpc(dnpc),
        .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string what, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string what, input cpu_pkg::reg_addr_t got,
                             input cpu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got x%0d expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // instruction assembly by field packing
    function automatic cpu_pkg::word_t r_type(input logic [6:0] f7,
            input cpu_pkg::reg_addr_t rs2, rs1, input logic [2:0] f3, input cpu_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic cpu_pkg::word_t i_type(input logic [11:0] imm, input cpu_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input cpu_pkg::reg_addr_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t s_type(input logic [11:0] imm,
            input cpu_pkg::reg_addr_t rs2, rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic cpu_pkg::word_t b_type(input logic [12:0] off,
            input cpu_pkg::reg_addr_t rs2, rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t u_type(input logic [19:0] imm,
            input cpu_pkg::reg_addr_t rd, input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t j_type(input logic [20:0] off, input cpu_pkg::reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic cpu_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // rv32i integer semantics, alt is instruction bit 30
    function automatic cpu_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                               input cpu_pkg::word_t a, b);
        cpu_pkg::word_t r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) r = $signed(a) >>> b[4:0];  // sign fill
                else r = a >> b[4:0];
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input cpu_pkg::word_t a, b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // gathers bytes from the model memory, then extends
    function automatic cpu_pkg::word_t load_ref(input logic [2:0] f3, input cpu_pkg::word_t addr);
        cpu_pkg::word_t w;
        cpu_pkg::word_t idx;
        for (int i = 0; i < 4; i++) begin
            idx = addr + i;
            w[8*i +: 8] = m_mem[idx[9:0]];
        end
        case (f3)
            3'b000: return {{24{w[7]}}, w[7:0]};    // lb
            3'b001: return {{16{w[15]}}, w[15:0]};  // lh
            3'b100: return {24'd0, w[7:0]};         // lbu
            3'b101: return {16'd0, w[15:0]};        // lhu
            default: return w;
        endcase
    endfunction

    // starts and ends on a falling edge, one instruction retired in between
    task automatic retire(input cpu_pkg::word_t instr, input logic wen, input cpu_pkg::reg_addr_t rd,
                          input cpu_pkg::word_t wdata, input cpu_pkg::word_t npc);
        cmd = instr;
        #1;  // combinational settle
        check_word("pc before edge", pc, exp_pc);
        check_word("dnpc", dnpc, npc);
        check_bit("rf_wen", rf_wen, wen);
        if (wen) begin
            check_reg("rf_waddr", rf_waddr, rd);
            check_word("rf_wdata", rf_wdata, wdata);
        end
        @(posedge clk);
        #1;
        if (wen && rd != 5'd0) m_regs[rd] = wdata;  // x0 stays zero
        exp_pc = npc;
        check_word("pc after edge", pc, exp_pc);
        @(negedge clk);
    endtask

    // lui + addi pair, upper part rounded for the signed low twelve
    task automatic load_reg(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t value);
        cpu_pkg::word_t upper;
        upper = value + 32'h800;
        upper[11:0] = 12'd0;
        retire(u_type(upper[31:12], rd, OPC_LUI), 1'b1, rd, upper, exp_pc + 4);
        retire(i_type(value[11:0], rd, 3'b000, rd, OPC_IMM), 1'b1, rd,
               upper + sext12(value[11:0]), exp_pc + 4);
    endtask

    task automatic test_sequential;
        retire(NOP, 1'b1, 5'd0, 32'd0, exp_pc + 4);
        for (int i = 1; i < 5; i++)
            retire(i_type(i[11:0], 0, 3'b000, 1, OPC_IMM), 1'b1, 1, i, exp_pc + 4);
    endtask

    task automatic test_arith;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        logic [11:0]    imm;
        logic [2:0]     f3;
        logic           alt;
        for (int n = 0; n < 3; n++) begin
            a = $random(seed);
            b = $random(seed);
            load_reg(5, a);
            load_reg(6, b);
            for (int f = 0; f < 8; f++) begin
                f3 = f[2:0];
                for (int k = 0; k < 2; k++) begin
                    alt = k[0];
                    if (!alt || f3 == 3'b000 || f3 == 3'b101)  // sub and sra only
                        retire(r_type({1'b0, alt, 5'd0}, 6, 5, f3, 7), 1'b1, 7,
                               alu_ref(f3, alt, m_regs[5], m_regs[6]), exp_pc + 4);
                end
                imm = $random(seed);
                alt = 1'b0;
                if (f3 == 3'b001) imm[11:5] = 7'd0;  // slli shamt only
                if (f3 == 3'b101) begin
                    alt = imm[10];
                    imm[11:5] = {1'b0, alt, 5'd0};
                end
                retire(i_type(imm, 5, f3, 8, OPC_IMM), 1'b1, 8,
                       alu_ref(f3, alt, m_regs[5], sext12(imm)), exp_pc + 4);
            end
        end
    endtask

    task automatic test_upper;
        logic [19:0] u;
        u = $random(seed);
        retire(u_type(u, 9, OPC_LUI), 1'b1, 9, {u, 12'd0}, exp_pc + 4);
        u = $random(seed);
        retire(u_type(u, 10, OPC_AUIPC), 1'b1, 10, exp_pc + {u, 12'd0}, exp_pc + 4);
        // x0 write visible on trace but not stored
        retire(i_type(12'h123, 5, 3'b000, 0, OPC_IMM), 1'b1, 0, m_regs[5] + 32'h123, exp_pc + 4);
        retire(r_type(7'd0, 0, 0, 3'b000, 11), 1'b1, 11, 32'd0, exp_pc + 4);
    endtask

    task automatic test_branch;
        logic [12:0]        off;
        cpu_pkg::reg_addr_t ra;
        cpu_pkg::reg_addr_t rb;
        cpu_pkg::word_t     npc;
        load_reg(12, 32'hffff_fffb);  // -5, huge when unsigned
        load_reg(13, 32'd3);
        load_reg(14, 32'd3);
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;  // no branch there
            for (int p = 0; p < 3; p++) begin
                ra = (p == 0) ? 5'd12 : 5'd13;
                rb = (p == 0) ? 5'd13 : ((p == 1) ? 5'd14 : 5'd12);
                off = $random(seed);
                off[0] = 1'b0;
                if (branch_taken(f[2:0], m_regs[ra], m_regs[rb]))
                    npc = exp_pc + {{19{off[12]}}, off};
                else
                    npc = exp_pc + 4;
                retire(b_type(off, rb, ra, f[2:0]), 1'b0, 0, 32'd0, npc);
            end
        end
    endtask

    task automatic test_jump;
        logic [20:0] joff;
        logic [11:0] imm;
        for (int n = 0; n < 2; n++) begin
            joff = $random(seed);
            joff[0] = 1'b0;
            retire(j_type(joff, 15), 1'b1, 15, exp_pc + 4, exp_pc + {{11{joff[20]}}, joff});
            load_reg(16, $random(seed));
            imm = $random(seed);
            retire(i_type(imm, 16, 3'b000, 17, OPC_JALR), 1'b1, 17, exp_pc + 4,
                   (m_regs[16] + sext12(imm)) & ~32'd1);  // bit 0 dropped
        end
    endtask

    // store via x19 off base x18, model memory follows
    task automatic store(input logic [2:0] f3, input int off, input cpu_pkg::word_t val);
        cpu_pkg::word_t addr;
        cpu_pkg::word_t idx;
        load_reg(19, val);
        addr = m_regs[18] + sext12(off[11:0]);
        retire(s_type(off[11:0], 19, 18, f3), 1'b0, 0, 32'd0, exp_pc + 4);
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            idx = addr + i;
            m_mem[idx[9:0]] = val[8*i +: 8];
        end
    endtask

    task automatic test_memory;
        logic [2:0] f3;
        load_reg(18, 32'h0000_0104);
        for (int o = -4; o < 12; o += 4) store(3'b010, o, $random(seed));  // fill 0x100..0x10f
        store(3'b001, 2, $random(seed));
        store(3'b001, 6, $random(seed));
        store(3'b000, -3, $random(seed));
        store(3'b000, 5, $random(seed));
        store(3'b000, 11, $random(seed));
        for (int k = 0; k < 5; k++) begin
            f3 = (k < 3) ? k[2:0] : k[2:0] + 3'd1;  // lb lh lw lbu lhu
            for (int o = -4; o < 12; o += (1 << f3[1:0]))
                retire(i_type(o[11:0], 18, f3, 20, OPC_LOAD), 1'b1, 20,
                       load_ref(f3, m_regs[18] + sext12(o[11:0])), exp_pc + 4);
        end
    endtask

    initial begin
        int cycles;
        rst    = 1'b1;
        cmd    = NOP;
        errors = 0;
        seed   = 32'hd62cdd01;
        exp_pc = cpu_pkg::RESET_VECTOR;
        foreach (m_regs[i]) m_regs[i] = '0;
        repeat (4) @(posedge clk);
        cycles = 0;
        while (pc !== cpu_pkg::RESET_VECTOR && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (pc !== cpu_pkg::RESET_VECTOR) begin
            $display("timeout: pc never reached the reset vector while rst was held");
            errors++;
        end else begin
            @(negedge clk);
            rst = 1'b0;  // first instruction retires on the next rising edge
            test_sequential();
            test_arith();
            test_upper();
            test_branch();
            test_jump();
            test_memory();
        end
        $display("checks finished with %0d errors", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== cpu.f ====
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/imm_decode.sv
hdl/register_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/data_mem.sv
hdl/cpu.sv
testbench/cpu_tb.sv
